//--- Bender.yml
package:
  name: conv_accel

sources:
  - src/conv_pkg.sv
  - src/host_ctrl.sv
  - src/conv_engine.sv
  - src/mem_arbiter.sv
  - src/data_mem.sv
  - src/conv_accel_top.sv
  - target: test
    files:
      - verif/conv_tb.sv

//--- src/conv_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_accel_top import conv_pkg::*; #(
    parameter int WT_DIM = 3
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              host_req_valid_i,
    input  host_req_t         host_req_i,
    output logic              host_req_ready_o,
    output logic              host_rsp_valid_o,
    output logic [DWIDTH-1:0] host_rsp_rdata_o
);

    logic              start;
    logic              eng_idle;
    logic              eng_done;
    conv_cfg_t         cfg;
    logic              host_mem_valid;
    logic              host_mem_ready;
    logic              host_mem_rsp_valid;
    mem_req_t          host_mem_req;
    logic              eng_mem_valid;
    logic              eng_mem_ready;
    logic              eng_mem_rsp_valid;
    mem_req_t          eng_mem_req;
    logic              mem_en;
    mem_req_t          mem_req;
    logic [DWIDTH-1:0] mem_rdata;
    logic [DWIDTH-1:0] arb_rdata;  // rdata as seen by both requesters

    host_ctrl u_host_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (host_req_valid_i),
        .req_i           (host_req_i),
        .req_ready_o     (host_req_ready_o),
        .rsp_valid_o     (host_rsp_valid_o),
        .rsp_rdata_o     (host_rsp_rdata_o),
        .start_o         (start),
        .cfg_o           (cfg),
        .eng_idle_i      (eng_idle),
        .eng_done_i      (eng_done),
        .mem_req_valid_o (host_mem_valid),
        .mem_req_o       (host_mem_req),
        .mem_ready_i     (host_mem_ready),
        .mem_rsp_valid_i (host_mem_rsp_valid),
        .mem_rdata_i     (arb_rdata)
    );

    conv_engine #(
        .WT_DIM (WT_DIM)
    ) u_conv_engine (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .start_i         (start),
        .cfg_i           (cfg),
        .idle_o          (eng_idle),
        .done_o          (eng_done),
        .mem_req_valid_o (eng_mem_valid),
        .mem_req_o       (eng_mem_req),
        .mem_ready_i     (eng_mem_ready),
        .mem_rsp_valid_i (eng_mem_rsp_valid),
        .mem_rdata_i     (arb_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .host_valid_i     (host_mem_valid),
        .host_req_i       (host_mem_req),
        .host_ready_o     (host_mem_ready),
        .host_rsp_valid_o (host_mem_rsp_valid),
        .eng_valid_i      (eng_mem_valid),
        .eng_req_i        (eng_mem_req),
        .eng_ready_o      (eng_mem_ready),
        .eng_rsp_valid_o  (eng_mem_rsp_valid),
        .rdata_o          (arb_rdata),
        .mem_en_o         (mem_en),
        .mem_req_o        (mem_req),
        .mem_rdata_i      (mem_rdata)
    );

    data_mem u_data_mem (
        .clk     (clk),
        .en_i    (mem_en),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

//--- src/conv_engine.sv
`timescale 1ns/1ns
`default_nettype none

module conv_engine import conv_pkg::*; #(
    parameter int WT_DIM = 3
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  conv_cfg_t         cfg_i,
    output logic              idle_o,
    output logic              done_o,
    output logic              mem_req_valid_o,
    output mem_req_t          mem_req_o,
    input  logic              mem_ready_i,
    input  logic              mem_rsp_valid_i,
    input  logic [DWIDTH-1:0] mem_rdata_i
);

    localparam int NWT = WT_DIM * WT_DIM;
    localparam int CW  = $clog2(NWT + 1);
    localparam int KW  = $clog2(WT_DIM + 1);
    localparam int IW  = 16;  // index math width, covers 255 x 255

    engine_state_e            state_q;
    logic [CW-1:0]            iss_cnt_q;   // requests granted in this phase
    logic [CW-1:0]            rsp_cnt_q;   // responses returned in this phase
    logic [KW-1:0]            ik_row_q;    // kernel position of next read
    logic [KW-1:0]            ik_col_q;
    logic [7:0]               out_row_q;
    logic [7:0]               out_col_q;
    logic [7:0]               out_dim;
    logic signed [DWIDTH-1:0] acc_q;
    logic signed [DWIDTH-1:0] prod;
    logic signed [DWIDTH-1:0] wt_q [NWT];
    logic [IW-1:0]            win_row;
    logic [IW-1:0]            win_col;
    logic [IW-1:0]            win_idx;
    logic [IW-1:0]            ofm_idx;
    logic                     issue;
    logic                     last_rsp;
    logic                     last_pos;

    assign idle_o   = (state_q == ST_IDLE);
    assign done_o   = (state_q == ST_DONE);  // single cycle state
    assign issue    = mem_req_valid_o && mem_ready_i;
    assign last_rsp = mem_rsp_valid_i && (rsp_cnt_q == CW'(NWT - 1));
    assign out_dim  = cfg_i.fm_dim - 8'(WT_DIM) + 8'd1;
    assign last_pos = (out_row_q == out_dim - 8'd1) && (out_col_q == out_dim - 8'd1);

    assign win_row = IW'(out_row_q) + IW'(ik_row_q);
    assign win_col = IW'(out_col_q) + IW'(ik_col_q);
    assign win_idx = win_row * IW'(cfg_i.fm_dim) + win_col;
    assign ofm_idx = IW'(out_row_q) * IW'(out_dim) + IW'(out_col_q);
    assign prod    = $signed(mem_rdata_i) * wt_q[rsp_cnt_q];  // low 32 bits kept

    always_comb begin
        case (state_q)
            ST_LOAD_WT, ST_WINDOW: mem_req_valid_o = (iss_cnt_q < CW'(NWT));
            ST_WRITE:              mem_req_valid_o = (iss_cnt_q == '0);
            default:               mem_req_valid_o = 1'b0;
        endcase
    end

    always_comb begin
        mem_req_o    = '0;
        mem_req_o.be = 4'hf;
        case (state_q)
            ST_LOAD_WT: mem_req_o.addr = cfg_i.wt_offset + MEM_AWIDTH'(iss_cnt_q);
            ST_WRITE: begin
                mem_req_o.addr  = cfg_i.ofm_offset + MEM_AWIDTH'(ofm_idx);
                mem_req_o.wdata = acc_q;
                mem_req_o.we    = 1'b1;
            end
            default:    mem_req_o.addr = cfg_i.ifm_offset + MEM_AWIDTH'(win_idx);
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            iss_cnt_q <= '0;
            rsp_cnt_q <= '0;
            ik_row_q  <= '0;
            ik_col_q  <= '0;
            out_row_q <= '0;
            out_col_q <= '0;
            acc_q     <= '0;
        end else begin
            if (issue) begin
                iss_cnt_q <= iss_cnt_q + 1'b1;
                if (ik_col_q == KW'(WT_DIM - 1)) begin
                    ik_col_q <= '0;
                    ik_row_q <= ik_row_q + 1'b1;
                end else begin
                    ik_col_q <= ik_col_q + 1'b1;
                end
            end
            if (mem_rsp_valid_i) begin
                rsp_cnt_q <= rsp_cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        // a map smaller than the kernel has no output
                        state_q   <= (cfg_i.fm_dim < 8'(WT_DIM)) ? ST_DONE : ST_LOAD_WT;
                        iss_cnt_q <= '0;
                        rsp_cnt_q <= '0;
                        out_row_q <= '0;
                        out_col_q <= '0;
                    end
                end
                ST_LOAD_WT, ST_WINDOW: begin
                    if (state_q == ST_WINDOW && mem_rsp_valid_i) begin
                        acc_q <= acc_q + prod;
                    end
                    if (last_rsp) begin
                        state_q   <= (state_q == ST_LOAD_WT) ? ST_WINDOW : ST_WRITE;
                        iss_cnt_q <= '0;
                        rsp_cnt_q <= '0;
                        ik_row_q  <= '0;
                        ik_col_q  <= '0;
                        if (state_q == ST_LOAD_WT) begin
                            acc_q <= '0;
                        end
                    end
                end
                ST_WRITE: begin
                    if (mem_rsp_valid_i) begin  // write acknowledged
                        iss_cnt_q <= '0;
                        rsp_cnt_q <= '0;
                        ik_row_q  <= '0;
                        ik_col_q  <= '0;
                        acc_q     <= '0;
                        if (last_pos) begin
                            state_q <= ST_DONE;
                        end else begin
                            state_q <= ST_WINDOW;
                            if (out_col_q == out_dim - 8'd1) begin
                                out_col_q <= '0;
                                out_row_q <= out_row_q + 8'd1;
                            end else begin
                                out_col_q <= out_col_q + 8'd1;
                            end
                        end
                    end
                end
                default: state_q <= ST_IDLE;  // ST_DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_LOAD_WT && mem_rsp_valid_i) begin
            wt_q[rsp_cnt_q] <= mem_rdata_i;  // row-major kernel
        end
    end

endmodule

`default_nettype wire

//--- src/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int DWIDTH      = 32;
    localparam int MEM_AWIDTH  = 14;  // 16384 words of data memory
    localparam int HOST_AWIDTH = 16;  // msb set selects the register space
    localparam int REG_AWIDTH  = 3;

    // register indices in the host register space
    localparam logic [REG_AWIDTH-1:0] REG_CTRL       = 3'd0;  // bit 0 starts the engine
    localparam logic [REG_AWIDTH-1:0] REG_STATUS     = 3'd1;  // bit 0 idle, bit 1 done
    localparam logic [REG_AWIDTH-1:0] REG_FM_DIM     = 3'd2;
    localparam logic [REG_AWIDTH-1:0] REG_WT_OFFSET  = 3'd3;
    localparam logic [REG_AWIDTH-1:0] REG_IFM_OFFSET = 3'd4;
    localparam logic [REG_AWIDTH-1:0] REG_OFM_OFFSET = 3'd5;

    typedef struct packed {
        logic [HOST_AWIDTH-1:0] addr;  // word address
        logic [DWIDTH-1:0]      wdata;
        logic [3:0]             be;
        logic                   we;
    } host_req_t;

    typedef struct packed {
        logic [MEM_AWIDTH-1:0] addr;
        logic [DWIDTH-1:0]     wdata;
        logic [3:0]            be;
        logic                  we;
    } mem_req_t;

    typedef struct packed {
        logic [7:0]            fm_dim;  // input map side length
        logic [MEM_AWIDTH-1:0] wt_offset;
        logic [MEM_AWIDTH-1:0] ifm_offset;
        logic [MEM_AWIDTH-1:0] ofm_offset;
    } conv_cfg_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_WT,
        ST_WINDOW,
        ST_WRITE,
        ST_DONE
    } engine_state_e;

endpackage

`default_nettype wire

//--- src/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem import conv_pkg::*; (
    input  logic              clk,
    input  logic              en_i,
    input  mem_req_t          req_i,
    output logic [DWIDTH-1:0] rdata_o
);

    localparam int DEPTH = 2 ** MEM_AWIDTH;

    logic [DWIDTH-1:0] mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.be[b]) begin
                        mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[req_i.addr];  // held through writes
            end
        end
    end

endmodule

`default_nettype wire

//--- src/host_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module host_ctrl import conv_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              req_valid_i,
    input  host_req_t         req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output logic [DWIDTH-1:0] rsp_rdata_o,
    output logic              start_o,
    output conv_cfg_t         cfg_o,
    input  logic              eng_idle_i,
    input  logic              eng_done_i,
    output logic              mem_req_valid_o,
    output mem_req_t          mem_req_o,
    input  logic              mem_ready_i,
    input  logic              mem_rsp_valid_i,
    input  logic [DWIDTH-1:0] mem_rdata_i
);

    logic                  busy_q;       // one request outstanding
    logic                  accept;
    logic                  reg_sel;
    logic [REG_AWIDTH-1:0] reg_idx;
    logic [DWIDTH-1:0]     reg_rdata;
    logic                  reg_rsp_q;
    logic [DWIDTH-1:0]     reg_rdata_q;
    logic                  done_q;       // sticky until next start
    logic                  start_req;

    assign req_ready_o = !busy_q;
    assign accept      = req_valid_i && req_ready_o;
    assign reg_sel     = req_i.addr[HOST_AWIDTH-1];
    assign reg_idx     = req_i.addr[REG_AWIDTH-1:0];
    assign start_req   = accept && reg_sel && req_i.we && (reg_idx == REG_CTRL)
                         && req_i.wdata[0] && eng_idle_i;  // busy engine ignores start

    assign rsp_valid_o = reg_rsp_q || mem_rsp_valid_i;
    assign rsp_rdata_o = reg_rsp_q ? reg_rdata_q : mem_rdata_i;

    always_comb begin
        case (reg_idx)
            REG_STATUS:     reg_rdata = {{(DWIDTH-2){1'b0}}, done_q, eng_idle_i};
            REG_FM_DIM:     reg_rdata = DWIDTH'(cfg_o.fm_dim);
            REG_WT_OFFSET:  reg_rdata = DWIDTH'(cfg_o.wt_offset);
            REG_IFM_OFFSET: reg_rdata = DWIDTH'(cfg_o.ifm_offset);
            REG_OFM_OFFSET: reg_rdata = DWIDTH'(cfg_o.ofm_offset);
            default:        reg_rdata = '0;  // ctrl and unused indices
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q          <= 1'b0;
            reg_rsp_q       <= 1'b0;
            mem_req_valid_o <= 1'b0;
            start_o         <= 1'b0;
            done_q          <= 1'b0;
            cfg_o           <= '0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (rsp_valid_o) begin
                busy_q <= 1'b0;  // ready again the cycle after the response
            end
            reg_rsp_q <= accept && reg_sel;
            if (accept && !reg_sel) begin
                mem_req_valid_o <= 1'b1;
            end else if (mem_req_valid_o && mem_ready_i) begin
                mem_req_valid_o <= 1'b0;
            end
            start_o <= start_req;
            if (start_req) begin
                done_q <= 1'b0;
            end else if (eng_done_i) begin
                done_q <= 1'b1;
            end
            if (accept && reg_sel && req_i.we) begin
                case (reg_idx)
                    REG_FM_DIM:     cfg_o.fm_dim     <= req_i.wdata[7:0];
                    REG_WT_OFFSET:  cfg_o.wt_offset  <= req_i.wdata[MEM_AWIDTH-1:0];
                    REG_IFM_OFFSET: cfg_o.ifm_offset <= req_i.wdata[MEM_AWIDTH-1:0];
                    REG_OFM_OFFSET: cfg_o.ofm_offset <= req_i.wdata[MEM_AWIDTH-1:0];
                    default:        ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_rdata_q     <= req_i.we ? '0 : reg_rdata;  // writes answer with 0
            mem_req_o.addr  <= req_i.addr[MEM_AWIDTH-1:0];
            mem_req_o.wdata <= req_i.wdata;
            mem_req_o.be    <= req_i.be;
            mem_req_o.we    <= req_i.we;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import conv_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              host_valid_i,
    input  mem_req_t          host_req_i,
    output logic              host_ready_o,
    output logic              host_rsp_valid_o,
    input  logic              eng_valid_i,
    input  mem_req_t          eng_req_i,
    output logic              eng_ready_o,
    output logic              eng_rsp_valid_o,
    output logic [DWIDTH-1:0] rdata_o,
    output logic              mem_en_o,
    output mem_req_t          mem_req_o,
    input  logic [DWIDTH-1:0] mem_rdata_i
);

    logic last_eng_q;  // engine won the last contested or single grant
    logic grant_eng;

    always_comb begin
        if (host_valid_i && eng_valid_i) begin
            grant_eng = !last_eng_q;  // alternate on contention
        end else begin
            grant_eng = eng_valid_i;
        end
    end

    assign eng_ready_o  = grant_eng;
    assign host_ready_o = host_valid_i && !grant_eng;
    assign mem_en_o     = host_valid_i || eng_valid_i;
    assign mem_req_o    = grant_eng ? eng_req_i : host_req_i;
    assign rdata_o      = mem_rdata_i;  // shared, steered by the valids

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_eng_q       <= 1'b0;
            host_rsp_valid_o <= 1'b0;
            eng_rsp_valid_o  <= 1'b0;
        end else begin
            if (mem_en_o) begin
                last_eng_q <= grant_eng;
            end
            host_rsp_valid_o <= host_ready_o;  // memory answers one cycle later
            eng_rsp_valid_o  <= eng_ready_o;
        end
    end

endmodule

`default_nettype wire

//--- verif/conv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_tb import conv_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int WT_DIM      = 3;
    localparam int NWT         = WT_DIM * WT_DIM;
    localparam int TB_SEED     = 32'h7af2bddd;
    localparam int HOST_OPS    = 700;         // rough bus access count over all tests
    localparam int HOST_OP_CYC = 8;
    localparam int WIN_CYC     = 2 * NWT + 6;  // window reads at half rate plus the write
    localparam int WINDOWS     = (4 - WT_DIM + 1) ** 2 + 2 * (8 - WT_DIM + 1) ** 2
                                 + (5 - WT_DIM + 1) ** 2;
    localparam int RUN_CYC     = 4 * WIN_CYC + WINDOWS * WIN_CYC;  // weight loads included
    localparam int TIMEOUT_CYC = 16 + HOST_OPS * HOST_OP_CYC + RUN_CYC + 1000;

    logic              clk;
    logic              arst_n_i;
    logic              host_req_valid;
    host_req_t         host_req;
    logic              host_req_ready;
    logic              host_rsp_valid;
    logic [DWIDTH-1:0] host_rsp_rdata;
    logic              outstanding;  // accepted request without response yet
    int                seed;
    int                pass_cnt;
    int                err_cnt;
    logic [DWIDTH-1:0] shadow [2**MEM_AWIDTH];  // what the host wrote to memory

    conv_accel_top #(
        .WT_DIM (WT_DIM)
    ) u_conv_accel_top (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .host_req_valid_i (host_req_valid),
        .host_req_i       (host_req),
        .host_req_ready_o (host_req_ready),
        .host_rsp_valid_o (host_rsp_valid),
        .host_rsp_rdata_o (host_rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding <= 1'b0;
        end else if (host_req_valid && host_req_ready) begin
            outstanding <= 1'b1;
        end else if (host_rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    reset_state: assert property (@(posedge clk)
        $rose(arst_n_i) |-> host_req_ready && !host_rsp_valid)
        else begin
            err_cnt++;
            $display("** Error at %0t: host port not idle after reset", $time);
        end

    reg_rsp_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
        host_req_valid && host_req_ready && host_req.addr[HOST_AWIDTH-1] |=> host_rsp_valid)
        else begin
            err_cnt++;
            $display("** Error at %0t: register response not one cycle after accept", $time);
        end

    ready_held_low: assert property (@(posedge clk) disable iff (!arst_n_i)
        outstanding |-> !host_req_ready)
        else begin
            err_cnt++;
            $display("** Error at %0t: ready high while a request is outstanding", $time);
        end

    function automatic int reg_addr(input logic [REG_AWIDTH-1:0] idx);
        return 32'h8000 | int'(idx);
    endfunction

    function automatic logic [DWIDTH-1:0] fill_word(input int addr);
        return 32'hf00d_0000 ^ (addr * 32'h0001_0001);  // whole address in both halves
    endfunction

    // valid convolution, stride 1, products summed mod 2^32
    function automatic logic [DWIDTH-1:0] model_word(input int wt, input int ifm, input int dim,
                                                     input int r, input int c);
        logic signed [DWIDTH-1:0] acc;
        acc = 0;
        for (int kr = 0; kr < WT_DIM; kr++) begin
            for (int kc = 0; kc < WT_DIM; kc++) begin
                acc += $signed(shadow[ifm + (r + kr) * dim + c + kc])
                       * $signed(shadow[wt + kr * WT_DIM + kc]);
            end
        end
        return acc;
    endfunction

    task automatic expect_word(input string what, input logic [DWIDTH-1:0] got,
                               input logic [DWIDTH-1:0] exp);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            err_cnt++;
            $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_transfer(input logic we, input int addr, input logic [DWIDTH-1:0] wdata,
                                input logic [3:0] be, output logic [DWIDTH-1:0] rdata);
        @(posedge clk);
        host_req_valid <= 1'b1;
        host_req.addr  <= HOST_AWIDTH'(addr);
        host_req.wdata <= wdata;
        host_req.be    <= be;
        host_req.we    <= we;
        @(negedge clk);
        while (!host_req_ready) @(negedge clk);
        @(posedge clk);  // accepted on this edge
        host_req_valid <= 1'b0;
        @(negedge clk);
        while (!host_rsp_valid) @(negedge clk);
        rdata = host_rsp_rdata;
    endtask

    task automatic host_write(input int addr, input logic [DWIDTH-1:0] data,
                              input logic [3:0] be);
        logic [DWIDTH-1:0] rsp_data;
        bus_transfer(1'b1, addr, data, be, rsp_data);
        if (addr < 2**MEM_AWIDTH) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[addr][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic host_read(input int addr, output logic [DWIDTH-1:0] data);
        bus_transfer(1'b0, addr, '0, 4'hf, data);
    endtask

    task automatic load_random(input int base, input int count);
        int v;
        for (int i = 0; i < count; i++) begin
            v = $random(seed) % 16;  // small signed values
            host_write(base + i, v, 4'hf);
        end
    endtask

    task automatic fill_region(input int base, input int count);
        for (int a = base - 1; a <= base + count; a++) begin
            host_write(a, fill_word(a), 4'hf);
        end
    endtask

    task automatic configure(input int dim, input int wt, input int ifm, input int ofm);
        host_write(reg_addr(REG_FM_DIM), dim, 4'hf);
        host_write(reg_addr(REG_WT_OFFSET), wt, 4'hf);
        host_write(reg_addr(REG_IFM_OFFSET), ifm, 4'hf);
        host_write(reg_addr(REG_OFM_OFFSET), ofm, 4'hf);
    endtask

    task automatic start_engine();
        host_write(reg_addr(REG_CTRL), 32'h1, 4'hf);
    endtask

    task automatic wait_done(input int dim);
        logic [DWIDTH-1:0] st;
        int                n;
        int                limit;
        n     = 0;
        st    = '0;
        limit = ((dim - WT_DIM + 1) ** 2 + 1) * WIN_CYC;
        while (!(st[1] && st[0]) && n < limit) begin
            host_read(reg_addr(REG_STATUS), st);
            n++;
        end
        if (!(st[1] && st[0])) begin
            err_cnt++;
            $display("status polled %0d times and the engine never reported done", n);
        end
    endtask

    task automatic verify_region(input int wt, input int ifm, input int ofm, input int dim);
        logic [DWIDTH-1:0] rd;
        int                od;
        od = dim - WT_DIM + 1;
        for (int r = 0; r < od; r++) begin
            for (int c = 0; c < od; c++) begin
                host_read(ofm + r * od + c, rd);
                expect_word($sformatf("output at %h", ofm + r * od + c), rd,
                            model_word(wt, ifm, dim, r, c));
            end
        end
        host_read(ofm - 1, rd);
        expect_word($sformatf("guard at %h", ofm - 1), rd, shadow[ofm - 1]);
        host_read(ofm + od * od, rd);
        expect_word($sformatf("guard at %h", ofm + od * od), rd, shadow[ofm + od * od]);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            $display("test %-24s ok", name);
        end else begin
            $display("test %-24s %0d errors", name, err_cnt - err_before);
        end
    endtask

    task automatic registers_readback();
        logic [DWIDTH-1:0] rd;
        int                e0;
        e0 = err_cnt;
        host_read(reg_addr(REG_STATUS), rd);
        expect_word("status after reset", rd, 32'h1);
        configure(32'h5c, 32'h1234, 32'h2a5b, 32'h3fff);
        host_write(reg_addr(3'd6), 32'hdead_beef, 4'hf);
        host_read(reg_addr(REG_FM_DIM), rd);
        expect_word("fm_dim register", rd, 32'h5c);
        host_read(reg_addr(REG_WT_OFFSET), rd);
        expect_word("weight offset", rd, 32'h1234);
        host_read(reg_addr(REG_IFM_OFFSET), rd);
        expect_word("input offset", rd, 32'h2a5b);
        host_read(reg_addr(REG_OFM_OFFSET), rd);
        expect_word("output offset", rd, 32'h3fff);
        host_read(reg_addr(3'd6), rd);
        expect_word("unused index 6", rd, 32'h0);
        host_read(reg_addr(3'd7), rd);
        expect_word("unused index 7", rd, 32'h0);
        report_test("register readback", e0);
    endtask

    task automatic memory_readback();
        logic [DWIDTH-1:0] rd;
        int                addrs [16];
        int                e0;
        e0 = err_cnt;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 32'h2000 + i * 64 + ($random(seed) & 63);  // distinct addresses
            host_write(addrs[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            host_read(addrs[i], rd);
            expect_word($sformatf("random word at %h", addrs[i]), rd, shadow[addrs[i]]);
        end
        host_write(32'h3000, 32'h1122_3344, 4'hf);
        host_write(32'h3000, 32'haabb_ccdd, 4'b0101);  // bytes 0 and 2 only
        host_read(32'h3000, rd);
        expect_word("partial byte write", rd, 32'h11bb_33dd);
        report_test("memory readback", e0);
    endtask

    task automatic small_conv();
        int e0;
        e0 = err_cnt;
        load_random(32'h100, NWT);
        load_random(32'h200, 16);
        fill_region(32'h300, 4);
        configure(4, 32'h100, 32'h200, 32'h300);
        start_engine();
        wait_done(4);
        verify_region(32'h100, 32'h200, 32'h300, 4);
        report_test("fm_dim 4 convolution", e0);
    endtask

    task automatic busy_engine_access();
        logic [DWIDTH-1:0] rd;
        int                e0;
        e0 = err_cnt;
        load_random(32'h400, NWT);
        load_random(32'h500, 64);
        fill_region(32'h600, 36);
        host_write(32'h3100, 32'h600d_cafe, 4'hf);  // outside all regions
        configure(8, 32'h400, 32'h500, 32'h600);
        start_engine();
        host_read(reg_addr(REG_STATUS), rd);
        expect_word("status while running", rd, 32'h0);
        host_read(32'h3100, rd);
        expect_word("word read during run", rd, 32'h600d_cafe);
        host_read(reg_addr(REG_STATUS), rd);
        expect_word("status after that read", rd, 32'h0);
        wait_done(8);
        verify_region(32'h400, 32'h500, 32'h600, 8);
        report_test("host access during run", e0);
    endtask

    task automatic repeated_runs();
        logic [DWIDTH-1:0] rd;
        int                e0;
        e0 = err_cnt;
        fill_region(32'h700, 36);
        configure(8, 32'h400, 32'h500, 32'h700);
        start_engine();
        start_engine();  // engine busy, so no effect
        host_read(reg_addr(REG_STATUS), rd);
        expect_word("status after second start", rd, 32'h0);
        wait_done(8);
        verify_region(32'h400, 32'h500, 32'h700, 8);
        host_read(reg_addr(REG_STATUS), rd);
        expect_word("status after first run", rd, 32'h3);
        load_random(32'h800, NWT);
        load_random(32'h900, 25);
        fill_region(32'ha00, 9);
        configure(5, 32'h800, 32'h900, 32'ha00);
        start_engine();
        host_read(reg_addr(REG_STATUS), rd);
        expect_word("status after new start", rd, 32'h0);
        wait_done(5);
        verify_region(32'h800, 32'h900, 32'ha00, 5);
        verify_region(32'h400, 32'h500, 32'h700, 8);  // earlier outputs untouched
        verify_region(32'h100, 32'h200, 32'h300, 4);
        report_test("restart and rerun", e0);
    endtask

    initial begin
        seed           = TB_SEED;
        pass_cnt       = 0;
        err_cnt        = 0;
        arst_n_i       = 1'b0;
        host_req_valid = 1'b0;
        host_req       = '0;
        repeat (16) @(posedge clk);
        arst_n_i <= 1'b1;
        registers_readback();
        memory_readback();
        small_conv();
        busy_engine_access();
        repeated_runs();
        $display("checks: %0d passed, %0d failed", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: test did not finish");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/conv_pkg.sv
src/host_ctrl.sv
src/conv_engine.sv
src/mem_arbiter.sv
src/data_mem.sv
src/conv_accel_top.sv
verif/conv_tb.sv
